// ==== logic/axi_word_pkg.sv ====
// link word format as delivered by the video-over-link receiver
// imported by the decoder, the serializer and the top level

package axi_word_pkg;

    // ======================================================================
    // received word
    // ======================================================================
    typedef logic [63:0] word_t;   // one 64-bit link word

    // kind field lives in bits 15:14 of every word
    typedef enum logic [1:0] {
        KIND_NONE   = 2'd0,   // filler, ignored
        KIND_SINGLE = 2'd1,   // one pixel in 39:16
        KIND_PAIR   = 2'd2,   // first pixel 39:16, second 63:40
        KIND_FRAME  = 2'd3    // frame start, marker in 63:16
    } word_kind_t;

    // marker required in 63:16 of a frame start word
    localparam logic [47:0] FRAME_MARKER = 48'hFEFE_FEFE_FEFE;

    // ======================================================================
    // ring queue entry, 50 bits
    // ======================================================================
    typedef struct packed {
        logic [23:0] pix_hi;   // second pixel of a pair
        logic [23:0] pix_lo;   // first (or only) pixel
        word_kind_t  kind;     // copied from the word
    } entry_t;

endpackage

// ==== logic/video_pkg.sv ====
// pixel and raster counter types, plus default 1080p60 timing
// the top level seeds its timing parameters from these defaults

package video_pkg;

    typedef logic [23:0] rgb_t;   // rgb888, r in 23:16
    typedef logic [11:0] cnt_t;   // h/v raster counter

    // ======================================================================
    // 1080p60 defaults, pixel clock 148.5 MHz
    // ======================================================================
    // horizontal, in pixel clocks
    localparam int DEF_H_SYNC  = 44;
    localparam int DEF_H_BACK  = 148;
    localparam int DEF_H_DISP  = 1920;
    localparam int DEF_H_FRONT = 88;    // total 2200

    // vertical, in lines
    localparam int DEF_V_SYNC  = 5;
    localparam int DEF_V_BACK  = 36;
    localparam int DEF_V_DISP  = 1080;
    localparam int DEF_V_FRONT = 4;     // total 1125

    // cycles from frame start strobe to raster enable
    localparam int DEF_START_DELAY = 8;

endpackage

// ==== logic/fifo_sync.sv ====
// single-clock show-ahead FIFO, head valid whenever empty is low
// payload type set per instance; push and pop allowed in one cycle

module fifo_sync #(
    parameter int  DEPTH     = 16,
    parameter type payload_t = logic [7:0]
) (
    input  logic     pixel_clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t wdata,
    input  logic     pop,
    output payload_t rdata,      // current head
    output logic     empty,
    output logic     full
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr, rd_ptr;
    logic [CW-1:0]   count;          // occupancy
    logic            do_push, do_pop;

    assign do_push = push && !full;   // push into a full FIFO is ignored
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == CW'(DEPTH));
    assign rdata = mem[rd_ptr];        // read straight from storage

    // storage, no reset
    always_ff @(posedge pixel_clk) begin
        if (do_push)
            mem[wr_ptr] <= wdata;
    end

    // pointers wrap at DEPTH-1, any depth works
    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // both or neither
            endcase
        end
    end

endmodule

// ==== logic/word_decoder.sv ====
// classifies link words; flags the first valid frame start and
// packs pixel words into ring entries once armed

module word_decoder (
    input  logic                 pixel_clk,
    input  logic                 rst_n,
    input  logic                 rx_valid,
    input  axi_word_pkg::word_t  rx_data,
    input  logic                 ring_full,
    output logic                 frame_start,   // one-cycle strobe
    output logic                 ring_push,
    output axi_word_pkg::entry_t ring_entry
);
    import axi_word_pkg::*;

    word_kind_t kind;
    logic       is_frame;     // kind 3 with full marker
    logic       is_pixel;     // single or pair
    logic       armed;        // set by first frame start

    assign kind     = word_kind_t'(rx_data[15:14]);
    assign is_frame = (kind == KIND_FRAME) && (rx_data[63:16] == FRAME_MARKER);
    assign is_pixel = (kind == KIND_SINGLE) || (kind == KIND_PAIR);

    // ======================================================================
    // frame start detect
    // ======================================================================
    // only the first marker counts, later ones are ignored
    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_start <= 1'b0;
            armed       <= 1'b0;
        end else begin
            frame_start <= rx_valid && is_frame && !armed;
            if (rx_valid && is_frame)
                armed <= 1'b1;
        end
    end

    // ======================================================================
    // entry packing
    // ======================================================================
    // written straight into the ring so the head updates next cycle
    // a full ring drops the word, source cannot be stalled
    assign ring_push = rx_valid && armed && is_pixel && !ring_full;

    always_comb begin
        ring_entry.kind   = kind;
        ring_entry.pix_lo = rx_data[39:16];                    // first pixel
        ring_entry.pix_hi = (kind == KIND_PAIR) ? rx_data[63:40] : '0;
    end

endmodule

// ==== logic/pixel_serializer.sv ====
// splits ring entries into single pixels, one per cycle
// pair = two cycles, entry popped together with its last pixel

module pixel_serializer (
    input  logic                 pixel_clk,
    input  logic                 rst_n,
    input  axi_word_pkg::entry_t ring_head,
    input  logic                 ring_empty,
    input  logic                 pix_full,
    output logic                 ring_pop,
    output logic                 pix_push,    // registered write strobe
    output video_pkg::rgb_t      pix_data
);
    import axi_word_pkg::*;
    import video_pkg::*;

    logic half_sel;     // first pixel of pair already sent
    logic advance;      // take a step this cycle
    logic is_pix;       // head carries pixels
    logic last;         // this step finishes the entry
    rgb_t next_pix;

    // pending write is held while the pixel FIFO is full
    assign advance  = !pix_full && !ring_empty;
    assign is_pix   = (ring_head.kind == KIND_SINGLE) || (ring_head.kind == KIND_PAIR);
    assign last     = (ring_head.kind != KIND_PAIR) || half_sel;  // kind none pops at once
    assign ring_pop = advance && last;
    assign next_pix = (ring_head.kind == KIND_PAIR && half_sel) ? ring_head.pix_hi
                                                                : ring_head.pix_lo;

    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_push <= 1'b0;
            half_sel <= 1'b0;
        end else if (!pix_full) begin
            pix_push <= advance && is_pix;
            if (advance && ring_head.kind == KIND_PAIR)
                half_sel <= !half_sel;    // lo then hi
        end
    end

    always_ff @(posedge pixel_clk) begin
        if (advance)
            pix_data <= next_pix;
    end

endmodule

// ==== logic/video_timing.sv ====
// raster generator: armed by frame_start after a fixed delay, then
// free-running h/v counters with registered hs, vs and de

module video_timing #(
    parameter int H_SYNC      = video_pkg::DEF_H_SYNC,
    parameter int H_BACK      = video_pkg::DEF_H_BACK,
    parameter int H_DISP      = video_pkg::DEF_H_DISP,
    parameter int H_FRONT     = video_pkg::DEF_H_FRONT,
    parameter int V_SYNC      = video_pkg::DEF_V_SYNC,
    parameter int V_BACK      = video_pkg::DEF_V_BACK,
    parameter int V_DISP      = video_pkg::DEF_V_DISP,
    parameter int V_FRONT     = video_pkg::DEF_V_FRONT,
    parameter int START_DELAY = video_pkg::DEF_START_DELAY
) (
    input  logic            pixel_clk,
    input  logic            rst_n,
    input  logic            frame_start,
    input  video_pkg::rgb_t pix_head,
    input  logic            pix_empty,
    output logic            pix_pop,
    output logic            video_hs,     // active low sync
    output logic            video_vs,     // active low sync
    output logic            video_de,
    output video_pkg::rgb_t video_rgb
);
    import video_pkg::*;

    localparam cnt_t H_TOTAL = cnt_t'(H_SYNC + H_BACK + H_DISP + H_FRONT);
    localparam cnt_t V_TOTAL = cnt_t'(V_SYNC + V_BACK + V_DISP + V_FRONT);
    localparam cnt_t H_ACT_BEG = cnt_t'(H_SYNC + H_BACK);
    localparam cnt_t H_ACT_END = cnt_t'(H_SYNC + H_BACK + H_DISP);
    localparam cnt_t V_ACT_BEG = cnt_t'(V_SYNC + V_BACK);
    localparam cnt_t V_ACT_END = cnt_t'(V_SYNC + V_BACK + V_DISP);
    localparam int   DW        = $clog2(START_DELAY + 1);

    logic [DW-1:0] delay_cnt;
    logic          sync_en;        // raster running
    cnt_t          h_cnt, v_cnt;
    logic          h_act, v_act;

    // ======================================================================
    // start delay
    // ======================================================================
    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            delay_cnt <= '0;
            sync_en   <= 1'b0;
        end else if (!sync_en) begin
            if (frame_start && delay_cnt == '0) begin
                delay_cnt <= DW'(START_DELAY);
            end else if (delay_cnt != '0) begin
                delay_cnt <= delay_cnt - 1'b1;
                if (delay_cnt == DW'(1))
                    sync_en <= 1'b1;            // runs freely from here
            end
        end
    end

    // ======================================================================
    // h/v counters and registered outputs
    // ======================================================================
    assign h_act = (h_cnt >= H_ACT_BEG) && (h_cnt < H_ACT_END);
    assign v_act = (v_cnt >= V_ACT_BEG) && (v_cnt < V_ACT_END);

    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt    <= '0;
            v_cnt    <= '0;
            video_hs <= 1'b0;
            video_vs <= 1'b0;
            video_de <= 1'b0;
        end else begin
            if (sync_en) begin
                if (h_cnt == H_TOTAL - 1'b1) begin      // end of line
                    h_cnt <= '0;
                    v_cnt <= (v_cnt == V_TOTAL - 1'b1) ? '0 : v_cnt + 1'b1;
                end else begin
                    h_cnt <= h_cnt + 1'b1;
                end
            end
            // one cycle behind the counters, all low until enabled
            video_hs <= sync_en && (h_cnt >= cnt_t'(H_SYNC));
            video_vs <= sync_en && (v_cnt >= cnt_t'(V_SYNC));
            video_de <= sync_en && h_act && v_act;
        end
    end

    // pop on every de cycle with data, black on underflow
    assign pix_pop   = video_de && !pix_empty;
    assign video_rgb = pix_pop ? pix_head : '0;

endmodule

// ==== logic/axi_video_top.sv ====
// link word stream in, raster video out, all on pixel_clk
// decoder -> ring queue -> serializer -> pixel FIFO -> timing generator

module axi_video_top #(
    parameter int H_SYNC      = video_pkg::DEF_H_SYNC,
    parameter int H_BACK      = video_pkg::DEF_H_BACK,
    parameter int H_DISP      = video_pkg::DEF_H_DISP,
    parameter int H_FRONT     = video_pkg::DEF_H_FRONT,
    parameter int V_SYNC      = video_pkg::DEF_V_SYNC,
    parameter int V_BACK      = video_pkg::DEF_V_BACK,
    parameter int V_DISP      = video_pkg::DEF_V_DISP,
    parameter int V_FRONT     = video_pkg::DEF_V_FRONT,
    parameter int START_DELAY = video_pkg::DEF_START_DELAY,
    parameter int PIX_DEPTH   = 1024,   // pixel FIFO depth
    parameter int RING_DEPTH  = 16      // entry queue depth
) (
    input  logic                pixel_clk,
    input  logic                rst_n,
    input  logic                rx_valid,     // word strobe, no backpressure
    input  axi_word_pkg::word_t rx_data,
    output logic                video_hs,
    output logic                video_vs,
    output logic                video_de,
    output video_pkg::rgb_t     video_rgb
);
    import axi_word_pkg::*;
    import video_pkg::*;

    // ======================================================================
    // internal nets
    // ======================================================================
    logic   frame_start;                       // decoder -> timing
    logic   ring_push, ring_pop, ring_full, ring_empty;
    entry_t ring_entry, ring_head;
    logic   pix_push, pix_pop, pix_full, pix_empty;
    rgb_t   pix_data, pix_head;

    word_decoder u_dec (
        .pixel_clk  (pixel_clk),
        .rst_n      (rst_n),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .ring_full  (ring_full),
        .frame_start(frame_start),
        .ring_push  (ring_push),
        .ring_entry (ring_entry)
    );

    // entry queue between decoder and serializer
    fifo_sync #(.DEPTH(RING_DEPTH), .payload_t(entry_t)) u_ring (
        .pixel_clk(pixel_clk), .rst_n(rst_n),
        .push(ring_push), .wdata(ring_entry), .pop(ring_pop),
        .rdata(ring_head), .empty(ring_empty), .full(ring_full)
    );

    pixel_serializer u_ser (
        .pixel_clk (pixel_clk),
        .rst_n     (rst_n),
        .ring_head (ring_head),
        .ring_empty(ring_empty),
        .pix_full  (pix_full),
        .ring_pop  (ring_pop),
        .pix_push  (pix_push),
        .pix_data  (pix_data)
    );

    // pixel queue feeding the raster
    fifo_sync #(.DEPTH(PIX_DEPTH), .payload_t(rgb_t)) u_pix (
        .pixel_clk(pixel_clk), .rst_n(rst_n),
        .push(pix_push), .wdata(pix_data), .pop(pix_pop),
        .rdata(pix_head), .empty(pix_empty), .full(pix_full)
    );

    video_timing #(
        .H_SYNC(H_SYNC), .H_BACK(H_BACK), .H_DISP(H_DISP), .H_FRONT(H_FRONT),
        .V_SYNC(V_SYNC), .V_BACK(V_BACK), .V_DISP(V_DISP), .V_FRONT(V_FRONT),
        .START_DELAY(START_DELAY)
    ) u_timing (
        .pixel_clk  (pixel_clk),
        .rst_n      (rst_n),
        .frame_start(frame_start),
        .pix_head   (pix_head),
        .pix_empty  (pix_empty),
        .pix_pop    (pix_pop),
        .video_hs   (video_hs),
        .video_vs   (video_vs),
        .video_de   (video_de),
        .video_rgb  (video_rgb)
    );

endmodule

// ==== dv/video_properties.sv ====
// raster output rules for video_timing
// attached to every video_timing instance by the bind below

module video_properties #(
    parameter int H_BACK = video_pkg::DEF_H_BACK,
    parameter int H_DISP = video_pkg::DEF_H_DISP
) (
    input logic pixel_clk,
    input logic rst_n,
    input logic frame_start,
    input logic pix_pop,
    input logic video_hs,
    input logic video_vs,
    input logic video_de
);
    import video_pkg::*;

    logic started;      // frame_start seen
    cnt_t hs_pos;       // cycles since hs went high
    logic in_window;    // active span of the line, seen from hs

    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n)
            started <= 1'b0;
        else if (frame_start)
            started <= 1'b1;
    end

    // restarts on every hs low cycle, counts up while hs is high
    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n)
            hs_pos <= '0;
        else if (!video_hs)
            hs_pos <= '0;
        else
            hs_pos <= hs_pos + 1'b1;
    end

    // back porch follows the hs rise, then the display span
    assign in_window = video_hs && (hs_pos >= cnt_t'(H_BACK))
                       && (hs_pos < cnt_t'(H_BACK + H_DISP));

    // ====================================================================
    // output rules
    // ====================================================================
    quiet_before_start: assert property (@(posedge pixel_clk) disable iff (!rst_n)
        !started |-> !video_hs && !video_vs && !video_de && !pix_pop)
        else $error("raster outputs active before frame_start");

    de_inside_sync: assert property (@(posedge pixel_clk) disable iff (!rst_n)
        video_de |-> video_hs && video_vs)      // no de during hs or vs low
        else $error("de high while hs or vs low");

    pop_only_on_de: assert property (@(posedge pixel_clk) disable iff (!rst_n)
        pix_pop |-> video_de && in_window)      // window taken from hs timing
        else $error("pixel pop outside the de window");

endmodule

bind video_timing video_properties #(
    .H_BACK(H_BACK),
    .H_DISP(H_DISP)
) u_props (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .frame_start(frame_start),
    .pix_pop    (pix_pop),
    .video_hs   (video_hs),
    .video_vs   (video_vs),
    .video_de   (video_de)
);

// ==== dv/tb_top.sv ====
// testbench for axi_video_top on a small 14x7 raster
// random pair/single words in, every de cycle checked against a reference model

module tb_top;
    import axi_word_pkg::*;
    import video_pkg::*;

    localparam int H_TOTAL     = 14;       // 2+2+8+2
    localparam int H_SYNC      = 2;
    localparam int FRAME       = 14 * 7;   // cycles per frame
    localparam int ACTIVE      = 8 * 4;    // de cycles per frame
    localparam int START_DELAY = 8;
    localparam int N_IDLE      = 100;      // unarmed words, 200 cycles
    localparam int N_PIX       = 64;       // two frames of pixels, fits the pixel FIFO

    typedef word_t word_q_t[$];
    typedef rgb_t  pix_q_t[$];

    logic  pixel_clk = 1'b0;
    logic  rst_n;
    logic  rx_valid;
    word_t rx_data;
    logic  video_hs, video_vs, video_de;
    rgb_t  video_rgb;

    word_q_t sent;       // every word driven, in order
    pix_q_t  exp_q;      // reference output, drained by the compare process
    int n_idle = 0, err_idle = 0, n_pix = 0, err_pix = 0, n_under = 0, err_under = 0;
    int n_per = 0, err_per = 0, n_frm = 0, err_frm = 0;
    int cyc = 0, last_fall = 0, de_cnt = 0, frames = 0;
    logic prev_hs = 1'b0, prev_vs = 1'b0;

    axi_video_top #(
        .H_SYNC(2), .H_BACK(2), .H_DISP(8), .H_FRONT(2),
        .V_SYNC(1), .V_BACK(1), .V_DISP(4), .V_FRONT(1),
        .START_DELAY(START_DELAY), .PIX_DEPTH(64), .RING_DEPTH(16)
    ) dut (
        .pixel_clk(pixel_clk), .rst_n(rst_n), .rx_valid(rx_valid), .rx_data(rx_data),
        .video_hs(video_hs), .video_vs(video_vs), .video_de(video_de), .video_rgb(video_rgb)
    );

    always #5 pixel_clk = ~pixel_clk;

    // ====================================================================
    // stimulus and reference model
    // ====================================================================
    function automatic word_t pixel_word();
        word_t w;
        w        = {$urandom, $urandom};             // unused bits stay random
        w[15:14] = ($urandom % 2 == 0) ? 2'd1 : 2'd2; // single or pair
        return w;
    endfunction

    task automatic build_stimulus();
        word_t w;
        int    npix;
        npix = 0;
        for (int i = 0; i < N_IDLE; i++) begin
            if (i == N_IDLE / 2)
                sent.push_back({48'hFEFE_FEFE_FEFF, 2'b11, 14'h0});  // marker off by one bit
            else
                sent.push_back(pixel_word());                        // dropped while unarmed
        end
        sent.push_back({48'hFEFE_FEFE_FEFE, 2'b11, 14'h0});          // real frame start
        while (npix < N_PIX) begin
            w = pixel_word();
            if (sent.size() == N_IDLE + 6)
                sent.push_back({w[63:16], 2'd0, w[13:0]});           // kind 0 filler
            else if (sent.size() == N_IDLE + 13)
                sent.push_back({48'hFEFE_FEFE_FEFE, 2'b11, 14'h0});  // second frame start
            sent.push_back(w);
            npix += (w[15:14] == 2'd2) ? 2 : 1;
        end
    endtask

    // kind rules from the word format, armed by the first marked frame start
    function automatic pix_q_t expected_pixels(input word_q_t words);
        pix_q_t pix;
        logic   armed;
        armed = 1'b0;
        foreach (words[i]) begin
            case (words[i][15:14])
                2'd3: if (words[i][63:16] == {6{8'hFE}}) armed = 1'b1;
                2'd2: if (armed) begin
                    pix.push_back(words[i][39:16]);   // first pixel
                    pix.push_back(words[i][63:40]);   // then second
                end
                2'd1: if (armed) pix.push_back(words[i][39:16]);
                default: ;                            // kind 0
            endcase
        end
        return pix;
    endfunction

    task automatic check_idle();
        n_idle++;
        assert (!video_hs && !video_vs && !video_de)
        else begin
            $display("Error: hs/vs/de = %h/%h/%h before frame start, expected 0/0/0",
                     video_hs, video_vs, video_de);
            err_idle++;
        end
    endtask

    task automatic report_test(input string name, input int checks, input int errs);
        $display("test %s: %0d checks, %0d errors", name, checks, errs);
    endtask

    // ====================================================================
    // compare and raster monitor, sampled at the falling edge
    // ====================================================================
    always @(negedge pixel_clk) begin : compare
        rgb_t expected;
        if (video_de && exp_q.size() > 0) begin
            expected = exp_q.pop_front();
            n_pix++;
            assert (video_rgb === expected)
            else begin
                $display("Error: video_rgb = %h, expected %h", video_rgb, expected);
                err_pix++;
            end
        end else if (video_de) begin        // model ran dry, black expected
            n_under++;
            assert (video_rgb === '0)
            else begin
                $display("Error: video_rgb = %h on underflow, expected %h", video_rgb, 24'h0);
                err_under++;
            end
        end
    end

    always @(negedge pixel_clk) begin : monitor
        cyc++;
        if (prev_hs && !video_hs) begin                    // hs falling edge
            if (last_fall > 0) begin
                n_per++;
                assert (cyc - last_fall == H_TOTAL)
                else begin
                    $display("hs falling edges %0d cycles apart instead of %0d",
                             cyc - last_fall, H_TOTAL);
                    err_per++;
                end
            end
            last_fall = cyc;
        end
        if (!prev_hs && video_hs && last_fall > 0) begin   // hs low width
            n_per++;
            assert (cyc - last_fall == H_SYNC)
            else begin
                $display("hs low for %0d cycles instead of %0d", cyc - last_fall, H_SYNC);
                err_per++;
            end
        end
        if (prev_vs && !video_vs) begin                    // frame boundary
            n_frm++;
            assert (de_cnt == ACTIVE)
            else begin
                $display("frame had %0d de cycles instead of %0d", de_cnt, ACTIVE);
                err_frm++;
            end
            de_cnt = 0;
            frames++;
        end
        if (video_de)
            de_cnt++;
        prev_hs = video_hs;
        prev_vs = video_vs;
    end

    // ====================================================================
    // main sequence
    // ====================================================================
    initial begin
        rst_n    = 1'b0;
        rx_valid = 1'b0;
        rx_data  = '0;
        void'($urandom(32'h0259_47e7));
        build_stimulus();
        exp_q = expected_pixels(sent);
        repeat (10) @(posedge pixel_clk);
        #1 rst_n = 1'b1;
        foreach (sent[i]) begin                            // one word every two cycles
            @(posedge pixel_clk);
            #1;
            if (i < N_IDLE)
                check_idle();
            if (i == N_IDLE)
                report_test("idle_after_reset", n_idle, err_idle);
            rx_valid = 1'b1;
            rx_data  = sent[i];
            @(posedge pixel_clk);
            #1 rx_valid = 1'b0;
            if (i < N_IDLE)
                check_idle();
        end
        wait (frames >= 2);
        report_test("pair_single_unpacking", n_pix, err_pix);
        report_test("continuous_frames", n_pix + n_frm, err_pix + err_frm);
        wait (frames >= 3);
        report_test("kind_filtering", n_pix + n_under + n_per, err_pix + err_under + err_per);
        report_test("underflow", n_under, err_under);
        report_test("raster_shape", n_per + n_frm, err_per + err_frm);
        $display("summary: %0d checks, %0d errors", n_idle + n_pix + n_under + n_per + n_frm,
                 err_idle + err_pix + err_under + err_per + err_frm);
        if (err_idle + err_pix + err_under + err_per + err_frm == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // reset, whole stimulus, start delay and three frames
    initial begin : watchdog
        int limit;
        wait (sent.size() > 0);
        limit = 10 + 2 * sent.size() + START_DELAY + 3 * FRAME;
        repeat (limit) @(posedge pixel_clk);
        $display("timeout: raster did not finish three frames within %0d cycles", limit);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== tb.f ====
logic/axi_word_pkg.sv
logic/video_pkg.sv
logic/fifo_sync.sv
logic/word_decoder.sv
logic/pixel_serializer.sv
logic/video_timing.sv
logic/axi_video_top.sv
dv/video_properties.sv
dv/tb_top.sv

// ==== Makefile ====
# Verilator build and run of tb_top, result taken from the log
OBJ := obj_dir
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module tb_top -Mdir $(OBJ)

run: build
	./$(OBJ)/Vtb_top | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module tb_top

clean:
	rm -rf $(OBJ) $(LOG)
